// ==== include/snd_config.svh ====
// SND_ACC_W must stay four bits wider than SND_PCM_W so the padded word keeps its 1+16+3 layout
`ifndef SND_CONFIG_SVH
`define SND_CONFIG_SVH

// Game sample coding
// 1 for two's complement, 0 for offset binary
`define SND_SIGNED 0

// DAC clock enable fires once every this many clk_dac cycles
`define SND_CEN_DIV 4

// Width of one game sample
`define SND_PCM_W 16

// Modulator input word
// One guard bit on top and three zero bits below the sample
`define SND_ACC_W 20

`endif

// ==== logic/snd_pkg.sv ====
// Both union members alias the same SND_PCM_W bits and only the decoding differs
`include "snd_config.svh"

package snd_pkg;

    // One game sample word
    // twos reads it as two's complement, offs as offset binary
    typedef union packed {
        logic signed [`SND_PCM_W-1:0] twos;
        logic        [`SND_PCM_W-1:0] offs;
    } pcm_sample_u;

    // Modulator input in offset binary
    // Top bit is always zero so full scale maps to half density
    typedef logic [`SND_ACC_W-1:0] dac_word_t;

endpackage

// ==== logic/snd_pcm_if.sv ====
// The cen signal is a single clk_dac cycle pulse and left/right only change on a cen
`timescale 1ns/100ps

interface snd_pcm_if import snd_pkg::*; ();

    // DAC clock enable
    logic        cen;

    // Held samples, raw bits in the game's coding
    pcm_sample_u left_smp;
    pcm_sample_u right;

    // Sample latch side
    modport source (
        output cen,
        output left_smp,
        output right
    );

    // Modulator side, channel picked at instantiation
    modport sink (
        input cen,
        input left_smp,
        input right
    );

endinterface

// ==== logic/snd_sample_latch.sv ====
// Game must hold both words stable while req_i is high and wait for ack_o low before a new request
`timescale 1ns/100ps
`include "snd_config.svh"

module snd_sample_latch import snd_pkg::*; (
    input  logic        clk_dac,
    input  logic        rst,
    input  logic        req_i,
    input  pcm_sample_u left_i,
    input  pcm_sample_u right_i,
    output logic        ack_o,
    snd_pcm_if.source   pcm
);

    // Ring start value puts the first cen on the third cycle after reset
    localparam logic [`SND_CEN_DIV-1:0] RING_INIT = {{(`SND_CEN_DIV-1){1'b0}}, 1'b1} << 2;

    logic                    req_s1;
    logic                    req_s2;
    logic                    cap;
    logic                    pend_vld;
    pcm_sample_u             pend_l;
    pcm_sample_u             pend_r;
    logic [`SND_CEN_DIV-1:0] ring;

    // Rising edge of the synchronized request
    // ack_o is the delayed copy, so this is high for one cycle
    assign cap = req_s2 & ~ack_o;

    assign pcm.cen = ring[0];

    // Two-flop synchronizer, then ack as the third stage
    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            req_s1 <= 1'b0;
            req_s2 <= 1'b0;
            ack_o  <= 1'b0;
        end else begin
            req_s1 <= req_i;
            req_s2 <= req_s1;
            ack_o  <= req_s2;
        end
    end

    // Enable ring, one hot bit rotating towards bit 0
    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            ring <= RING_INIT;
        end else begin
            ring <= {ring[0], ring[`SND_CEN_DIV-1:1]};
        end
    end

    // Pending pair
    // A newer capture simply overwrites an older one not yet used
    always_ff @(posedge clk_dac) begin
        if (cap) begin
            pend_l <= left_i;
            pend_r <= right_i;
        end
    end

    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            pend_vld <= 1'b0;
        end else begin
            if (pcm.cen && pend_vld) begin
                pend_vld <= 1'b0;
            end
            // Capture wins over the clear on the same edge
            if (cap) begin
                pend_vld <= 1'b1;
            end
        end
    end

    // Held samples only move on a cen
    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            pcm.left_smp <= '0;
            pcm.right    <= '0;
        end else if (pcm.cen && pend_vld) begin
            pcm.left_smp <= pend_l;
            pcm.right    <= pend_r;
        end
    end

endmodule

// ==== logic/snd_sdm_dac.sv ====
// Input never exceeds half of full scale and the loop state only advances when cen_i is high
`timescale 1ns/100ps
`include "snd_config.svh"

module snd_sdm_dac import snd_pkg::*; (
    input  logic        clk_dac,
    input  logic        rst,
    input  logic        cen_i,
    input  pcm_sample_u sample_i,
    output logic        pwm_o
);

    // Integrators get four bits of headroom over the DAC word
    localparam int SUM_W = `SND_ACC_W + 4;

    typedef logic signed [SUM_W-1:0] acc_t;
    typedef logic signed [SUM_W+1:0] wide_t;

    localparam acc_t  ACC_MAX = {1'b0, {(SUM_W-1){1'b1}}};
    localparam acc_t  ACC_MIN = {1'b1, {(SUM_W-1){1'b0}}};
    localparam wide_t FULL    = wide_t'(1) << `SND_ACC_W;

    logic [`SND_PCM_W-1:0] ob;
    dac_word_t             dac_word;
    wide_t                 x_w;
    wide_t                 fb;
    wide_t                 i1_sum;
    wide_t                 i2_sum;
    acc_t                  i1;
    acc_t                  i2;
    acc_t                  i1_nxt;
    acc_t                  i2_nxt;
    logic                  q;

    // Clamp a wide sum into the integrator range
    function automatic acc_t sat(input wide_t v);
        acc_t r;
        if (v > wide_t'(ACC_MAX)) begin
            r = ACC_MAX;
        end else if (v < wide_t'(ACC_MIN)) begin
            r = ACC_MIN;
        end else begin
            r = acc_t'(v);
        end
        return r;
    endfunction

    // Signed samples get the sign bit flipped
    assign ob = (`SND_SIGNED != 0) ?
                {~sample_i.twos[`SND_PCM_W-1], sample_i.twos[`SND_PCM_W-2:0]} :
                sample_i.offs;

    // Guard bit, sample, then zero fill
    assign dac_word = {1'b0, ob, {(`SND_ACC_W-`SND_PCM_W-1){1'b0}}};
    assign x_w      = wide_t'(dac_word);

    // Quantizer fires on a strictly positive second integrator
    // so an all-zero state stays silent
    assign q  = (i2 > 0);
    assign fb = q ? FULL : wide_t'(0);

    // Second integrator takes the updated first one, giving NTF (1-z^-1)^2
    assign i1_sum = wide_t'(i1) + x_w - fb;
    assign i1_nxt = sat(i1_sum);
    assign i2_sum = wide_t'(i2) + wide_t'(i1_nxt) - fb;
    assign i2_nxt = sat(i2_sum);

    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            i1    <= '0;
            i2    <= '0;
            pwm_o <= 1'b0;
        end else if (cen_i) begin
            i1    <= i1_nxt;
            i2    <= i2_nxt;
            pwm_o <= q;
        end
    end

endmodule

// ==== logic/snd_dac_top.sv ====
// Always stereo and snd_left_i/snd_right_i must use the coding that SND_SIGNED selects
`timescale 1ns/100ps

module snd_dac_top import snd_pkg::*; (
    input  logic        clk_dac,
    input  logic        rst,
    // Game side, four-phase handshake
    input  logic        snd_req_i,
    input  pcm_sample_u snd_left_i,
    input  pcm_sample_u snd_right_i,
    output logic        snd_ack_o,
    // 1-bit DAC pins
    output logic        snd_pwm_left_o,
    output logic        snd_pwm_right_o
);

    snd_pcm_if pcm ();

    snd_sample_latch i_latch (
        .clk_dac ( clk_dac     ),
        .rst     ( rst         ),
        .req_i   ( snd_req_i   ),
        .left_i  ( snd_left_i  ),
        .right_i ( snd_right_i ),
        .ack_o   ( snd_ack_o   ),
        .pcm     ( pcm.source  )
    );

    // Both channels share the enable from the latch
    snd_sdm_dac i_dac_left (
        .clk_dac  ( clk_dac        ),
        .rst      ( rst            ),
        .cen_i    ( pcm.cen        ),
        .sample_i ( pcm.left_smp   ),
        .pwm_o    ( snd_pwm_left_o )
    );

    snd_sdm_dac i_dac_right (
        .clk_dac  ( clk_dac         ),
        .rst      ( rst             ),
        .cen_i    ( pcm.cen         ),
        .sample_i ( pcm.right       ),
        .pwm_o    ( snd_pwm_right_o )
    );

endmodule

// ==== tb/snd_dac_tb.sv ====
// Fixed rows are offset-binary levels converted to the game coding, counts sample one bit per enable
`timescale 1ns/100ps
`include "snd_config.svh"

module snd_dac_tb import snd_pkg::*; ();

    localparam int FIXED_ROWS   = 8;
    localparam int RAND_ROWS    = 8;
    localparam int ROWS         = FIXED_ROWS + RAND_ROWS;
    localparam int SETTLE_PER   = 64;
    localparam int COUNT_PER    = 4096;
    localparam int TOL          = 8;
    localparam int RESET_CYCLES = 4;
    localparam int IDLE_CYCLES  = 32;
    localparam int ACK_DELAY    = 3;
    localparam int HS_CYCLES    = 16;
    localparam int ROW_CYCLES   = HS_CYCLES + (SETTLE_PER + COUNT_PER) * `SND_CEN_DIV;
    localparam int CYCLE_LIMIT  =
        (5 * (ROWS * ROW_CYCLES + RESET_CYCLES + IDLE_CYCLES)) / 4;

    logic        clk_dac;
    logic        rst;
    logic        snd_req;
    pcm_sample_u snd_left;
    pcm_sample_u snd_right;
    logic        snd_ack;
    logic        pwm_left;
    logic        pwm_right;

    // Stimulus and expected one-counts, one entry per row
    pcm_sample_u left_tab      [ROWS];
    pcm_sample_u right_tab     [ROWS];
    int          exp_left_tab  [ROWS];
    int          exp_right_tab [ROWS];

    logic [31:0] lfsr      = 32'h3e5c3dd9;
    int          cycle_cnt = 0;
    int          n_checks  = 0;
    int          n_errors  = 0;

    snd_dac_top i_dut (
        .clk_dac         ( clk_dac   ),
        .rst             ( rst       ),
        .snd_req_i       ( snd_req   ),
        .snd_left_i      ( snd_left  ),
        .snd_right_i     ( snd_right ),
        .snd_ack_o       ( snd_ack   ),
        .snd_pwm_left_o  ( pwm_left  ),
        .snd_pwm_right_o ( pwm_right )
    );

    initial clk_dac = 1'b0;
    always #50 clk_dac = ~clk_dac;

    // Run limit
    always @(posedge clk_dac) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Run stopped after %0d clk_dac cycles, the tests did not finish in time",
                     cycle_cnt);
            $display("Verification failed");
            $finish;
        end
    end

    // Galois LFSR, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    // One LFSR step per bit taken
    task automatic take_bits(input int n, output logic [`SND_PCM_W-1:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[`SND_PCM_W-2:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // Offset-binary level into the coding the game uses
    function automatic pcm_sample_u to_game(input logic [`SND_PCM_W-1:0] level);
        pcm_sample_u s;
        s.offs = level;
        if (`SND_SIGNED != 0) begin
            s.offs[`SND_PCM_W-1] = ~level[`SND_PCM_W-1];
        end
        return s;
    endfunction

    // Ones expected over COUNT_PER enables for one game word
    function automatic int expected_ones(input pcm_sample_u smp);
        logic [`SND_PCM_W-1:0] ob;
        longint                padded;
        ob = smp.offs;
        if (`SND_SIGNED != 0) begin
            ob[`SND_PCM_W-1] = ~ob[`SND_PCM_W-1];
        end
        // Guard bit on top, three zero bits below the sample
        padded = longint'(ob) << (`SND_ACC_W - `SND_PCM_W - 1);
        return int'((padded * COUNT_PER) >> `SND_ACC_W);
    endfunction

    task automatic set_row(input int i, input logic [`SND_PCM_W-1:0] l,
                           input logic [`SND_PCM_W-1:0] r);
        left_tab[i]      = to_game(l);
        right_tab[i]     = to_game(r);
        exp_left_tab[i]  = expected_ones(left_tab[i]);
        exp_right_tab[i] = expected_ones(right_tab[i]);
    endtask

    task automatic build_table();
        logic [`SND_PCM_W-1:0] l;
        logic [`SND_PCM_W-1:0] r;
        // Negative full scale first, while both loops still sit at reset state
        set_row(0, 16'h0000, 16'h0000);
        set_row(1, 16'h0000, 16'hffff);
        set_row(2, 16'h8000, 16'h8000);
        set_row(3, 16'hffff, 16'hffff);
        set_row(4, 16'h4000, 16'hc000);
        set_row(5, 16'hc000, 16'h4000);
        set_row(6, 16'hffff, 16'h8000);
        set_row(7, 16'h1234, 16'hedcb);
        for (int i = FIXED_ROWS; i < ROWS; i++) begin
            take_bits(`SND_PCM_W, l);
            take_bits(`SND_PCM_W, r);
            set_row(i, l, r);
        end
    endtask

    task automatic report(input bit ok, input string msg);
        n_checks++;
        if (ok) begin
            $display("ok    %s", msg);
        end else begin
            n_errors++;
            $display("ERROR at %0d ns: %s", $time, msg);
        end
    endtask

    task automatic check_ack(input string what, input int expected, input int got);
        report(got == expected,
               $sformatf("%s after %0d cycles, expected %0d", what, got, expected));
    endtask

    task automatic check_density(input string what, input pcm_sample_u smp,
                                 input int expected, input int got);
        int diff;
        diff = got - expected;
        if (diff < 0) begin
            diff = -diff;
        end
        report(diff <= TOL, $sformatf("%s word %h: %0d ones, expected %0d +/- %0d",
                                      what, smp, got, expected, TOL));
    endtask

    task automatic check_level(input string what, input logic expected, input logic got);
        report(got === expected,
               $sformatf("%s level %b, expected %b", what, got, expected));
    endtask

    // Rising edges until ack reaches the level, looked at on falling edges
    task automatic count_edges_until(input logic level, output int n);
        n = 0;
        @(negedge clk_dac);
        while (snd_ack !== level && n < HS_CYCLES) begin
            @(posedge clk_dac);
            n++;
            @(negedge clk_dac);
        end
    endtask

    // Four-phase handshake for one table row
    task automatic send_pair(input int row);
        int rise;
        int fall;
        // Game side waits for ack low before a new request
        @(negedge clk_dac);
        while (snd_ack !== 1'b0) begin
            @(negedge clk_dac);
        end
        @(posedge clk_dac);
        snd_left  <= left_tab[row];
        snd_right <= right_tab[row];
        @(posedge clk_dac);
        snd_req <= 1'b1;
        count_edges_until(1'b1, rise);
        check_ack($sformatf("row %0d ack rise", row), ACK_DELAY, rise);
        @(posedge clk_dac);
        snd_req <= 1'b0;
        count_edges_until(1'b0, fall);
        check_ack($sformatf("row %0d ack fall", row), ACK_DELAY, fall);
    endtask

    // The output holds for a whole enable period, so one sample per period
    task automatic count_ones(output int ones_l, output int ones_r);
        ones_l = 0;
        ones_r = 0;
        repeat (SETTLE_PER * `SND_CEN_DIV) @(posedge clk_dac);
        repeat (COUNT_PER) begin
            @(negedge clk_dac);
            ones_l += int'(pwm_left);
            ones_r += int'(pwm_right);
            repeat (`SND_CEN_DIV - 1) @(negedge clk_dac);
        end
    endtask

    // Outputs must stay quiet between reset and the first request
    task automatic check_idle();
        logic seen_ack;
        logic seen_l;
        logic seen_r;
        seen_ack = 1'b0;
        seen_l   = 1'b0;
        seen_r   = 1'b0;
        repeat (IDLE_CYCLES) begin
            @(negedge clk_dac);
            seen_ack = seen_ack | snd_ack;
            seen_l   = seen_l | pwm_left;
            seen_r   = seen_r | pwm_right;
        end
        check_level("idle snd_ack_o", 1'b0, seen_ack);
        check_level("idle snd_pwm_left_o", 1'b0, seen_l);
        check_level("idle snd_pwm_right_o", 1'b0, seen_r);
    endtask

    initial begin
        int ones_l;
        int ones_r;
        rst       <= 1'b1;
        snd_req   <= 1'b0;
        snd_left  <= '0;
        snd_right <= '0;
        build_table();
        repeat (RESET_CYCLES) @(posedge clk_dac);
        rst <= 1'b0;
        check_idle();

        for (int row = 0; row < ROWS; row++) begin
            send_pair(row);
            count_ones(ones_l, ones_r);
            check_density($sformatf("row %0d left", row), left_tab[row],
                          exp_left_tab[row], ones_l);
            check_density($sformatf("row %0d right", row), right_tab[row],
                          exp_right_tab[row], ones_r);
        end

        $display("Checks run: %0d, failed: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+include
logic/snd_pkg.sv
logic/snd_pcm_if.sv
logic/snd_sample_latch.sv
logic/snd_sdm_dac.sv
logic/snd_dac_top.sv
tb/snd_dac_tb.sv

// ==== Makefile ====
# Verilator build and run of the audio DAC testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0
TOP       := snd_dac_tb
FILELIST  := sim.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Verification passed

SRCS    := $(shell grep -v '^+' $(FILELIST))
HDRS    := $(wildcard include/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source, header or the file list changes
$(SIM_BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# The log decides pass or fail
run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q -x "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
